// File: files.f
+incdir+.
zc_pkg.sv
edge_frame_ram.sv
visited_map.sv
raster_scan_counter.sv
contour_tracer_fsm.sv
zebra_crossing_detector.sv
zc_tb.sv

// File: Bender.yml
package:
  name: zebra_crossing_detector

sources:
  - include_dirs:
      - .
    files:
      - zc_pkg.sv
      - edge_frame_ram.sv
      - visited_map.sv
      - raster_scan_counter.sv
      - contour_tracer_fsm.sv
      - zebra_crossing_detector.sv
  - target: test
    include_dirs:
      - .
    files:
      - zc_tb.sv

// File: zc_tb_model.svh
`ifndef ZC_TB_MODEL_SVH
`define ZC_TB_MODEL_SVH

// Reference frame and the visited bits of the model trace
logic model_frame [zc_pkg::PIX_COUNT];
logic model_seen [zc_pkg::PIX_COUNT];

function automatic int pixel_index(input int x, input int y);
    return y * `ZC_IMG_WIDTH + x;
endfunction

function automatic void clear_frame();
    int a;
    for (a = 0; a < zc_pkg::PIX_COUNT; a++) begin
        model_frame[a] = 1'b0;
    end
endfunction

// Pixels outside the image are dropped
function automatic void set_pixel(input int x, input int y);
    if (x >= 0 && x < `ZC_IMG_WIDTH && y >= 0 && y < `ZC_IMG_HEIGHT) begin
        model_frame[pixel_index(x, y)] = 1'b1;
    end
endfunction

function automatic void draw_rect_outline(input int x0, input int y0, input int w, input int h);
    int i;
    for (i = 0; i < w; i++) begin
        set_pixel(x0 + i, y0);
        set_pixel(x0 + i, y0 + h - 1);
    end
    for (i = 0; i < h; i++) begin
        set_pixel(x0, y0 + i);
        set_pixel(x0 + w - 1, y0 + i);
    end
endfunction

function automatic void scatter_noise(input int count);
    int i;
    for (i = 0; i < count; i++) begin
        set_pixel(rand_range(0, `ZC_IMG_WIDTH - 1), rand_range(0, `ZC_IMG_HEIGHT - 1));
    end
endfunction

function automatic bit in_window(input int x, input int y);
    return (x >= `ZC_BORDER) && (x < `ZC_IMG_WIDTH - `ZC_BORDER)
        && (y >= `ZC_BORDER) && (y < `ZC_IMG_HEIGHT - `ZC_BORDER);
endfunction

// Neighbor order NW, N, NE, W, E, SW, S, SE
function automatic int offset_x(input int k);
    case (k)
        0, 3, 5: return -1;
        1, 6: return 0;
        default: return 1;
    endcase
endfunction

function automatic int offset_y(input int k);
    if (k < 3) begin
        return -1;
    end else if (k < 5) begin
        return 0;
    end else begin
        return 1;
    end
endfunction

// Raster scan with contour following, one count per closed contour
function automatic zc_pkg::zc_result_t expected_result();
    int count;
    int x;
    int y;
    int k;
    int nx;
    int ny;
    int sx;
    int sy;
    int cx;
    int cy;
    int px;
    int py;
    int len;
    bit tracing;
    bit moved;
    zc_pkg::zc_result_t res;
    count = 0;
    for (k = 0; k < zc_pkg::PIX_COUNT; k++) begin
        model_seen[k] = 1'b0;
    end
    for (y = `ZC_BORDER; y < `ZC_IMG_HEIGHT - `ZC_BORDER; y++) begin
        for (x = `ZC_BORDER; x < `ZC_IMG_WIDTH - `ZC_BORDER; x++) begin
            if (model_frame[pixel_index(x, y)] && !model_seen[pixel_index(x, y)]) begin
                sx = x;
                sy = y;
                cx = x;
                cy = y;
                px = x;
                py = y;
                len = 1;
                model_seen[pixel_index(x, y)] = 1'b1;
                tracing = 1'b1;
                while (tracing) begin
                    moved = 1'b0;
                    k = 0;
                    while (tracing && !moved && k < 8) begin
                        nx = cx + offset_x(k);
                        ny = cy + offset_y(k);
                        if (in_window(nx, ny)) begin
                            if (model_frame[pixel_index(nx, ny)]) begin
                                if (nx == sx && ny == sy && len >= `ZC_MIN_EDGE_LENGTH) begin
                                    count++;
                                    tracing = 1'b0;
                                end else if (!model_seen[pixel_index(nx, ny)]
                                             && !(nx == px && ny == py)) begin
                                    px = cx;
                                    py = cy;
                                    cx = nx;
                                    cy = ny;
                                    len++;
                                    model_seen[pixel_index(nx, ny)] = 1'b1;
                                    moved = 1'b1;
                                end
                            end
                        end
                        k++;
                    end
                    // Dead end or closed contour
                    if (!moved) begin
                        tracing = 1'b0;
                    end
                end
            end
        end
    end
    res.stripe_count = zc_pkg::stripe_cnt_t'(count);
    res.crossing = (count >= `ZC_MIN_STRIPES);
    return res;
endfunction

`endif

// File: zc_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "zc_params.svh"

module zc_tb;

    localparam int DONE_TIMEOUT = 40000;
    localparam int IDLE_WATCH = 40;

    logic               clk;
    logic               rst_n;
    zc_pkg::pix_wr_t    pix_wr;
    logic               start;
    logic               busy;
    logic               done;
    zc_pkg::zc_result_t result;

    logic [31:0] lcg_state;
    int          error_cnt;
    int          pass_cnt;
    int          fail_cnt;

    zebra_crossing_detector i_dut (
        .clk    (clk),
        .rst_n  (rst_n),
        .pix_wr (pix_wr),
        .start  (start),
        .busy   (busy),
        .done   (done),
        .result (result)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Uniform pick from the upper LCG bits
    function automatic int rand_range(input int lo, input int hi);
        return lo + int'((next_rand() >> 8) % 32'(hi - lo + 1));
    endfunction

    `include "zc_tb_model.svh"

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic load_frame();
        int a;
        for (a = 0; a < zc_pkg::PIX_COUNT; a++) begin
            pix_wr.en = 1'b1;
            pix_wr.addr = zc_pkg::pix_addr_t'(a);
            pix_wr.data = model_frame[a];
            tick();
        end
        pix_wr = '0;
    endtask

    task automatic pulse_start();
        start = 1'b1;
        tick();
        start = 1'b0;
    endtask

    task automatic wait_for_done(input string name, output bit seen);
        int cycles;
        seen = 1'b0;
        cycles = 0;
        while (!seen && cycles < DONE_TIMEOUT) begin
            tick();
            cycles++;
            if (done) begin
                seen = 1'b1;
            end else begin
                assert (busy) else begin
                    $display("Error in %s: busy went low before done", name);
                    error_cnt++;
                end
            end
        end
        assert (seen) else begin
            $display("Error in %s: no done pulse within %0d cycles", name, DONE_TIMEOUT);
            error_cnt++;
        end
    endtask

    task automatic check_result(input string name, input zc_pkg::zc_result_t exp);
        assert (result == exp) else begin
            $display(
                "Mismatch in %s: expected count=%0d crossing=%0b, actual count=%0d crossing=%0b",
                name, exp.stripe_count, exp.crossing, result.stripe_count, result.crossing);
            error_cnt++;
        end
    endtask

    task automatic run_pass(input string name, input zc_pkg::zc_result_t exp);
        bit seen;
        pulse_start();
        wait_for_done(name, seen);
        if (seen) begin
            check_result(name, exp);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (error_cnt == errs_before) begin
            pass_cnt++;
            $display("Test %s passed", name);
        end else begin
            fail_cnt++;
            $display("Test %s failed with %0d errors", name, error_cnt - errs_before);
        end
    endtask

    task automatic empty_frame();
        int errs;
        zc_pkg::zc_result_t exp;
        errs = error_cnt;
        assert (!busy && !done && result == '0) else begin
            $display("Error in empty_frame: outputs not idle after reset");
            error_cnt++;
        end
        clear_frame();
        exp = expected_result();
        load_frame();
        run_pass("empty_frame", exp);
        report_test("empty_frame", errs);
    endtask

    task automatic three_stripes();
        int errs;
        int band;
        int w;
        int h;
        zc_pkg::zc_result_t exp;
        errs = error_cnt;
        clear_frame();
        // Bands of 9 columns keep the outlines apart
        for (band = 0; band < 3; band++) begin
            w = rand_range(5, 7);
            h = rand_range(5, 12);
            draw_rect_outline(`ZC_BORDER + band * 9 + rand_range(0, 8 - w),
                              rand_range(`ZC_BORDER, `ZC_IMG_HEIGHT - `ZC_BORDER - h), w, h);
        end
        exp = expected_result();
        assert (exp.stripe_count == 3 && exp.crossing) else begin
            $display("Error in three_stripes: model does not see three stripes");
            error_cnt++;
        end
        load_frame();
        run_pass("three_stripes", exp);
        report_test("three_stripes", errs);
    endtask

    task automatic short_outlines();
        int errs;
        zc_pkg::zc_result_t exp;
        errs = error_cnt;
        clear_frame();
        draw_rect_outline(rand_range(11, 16), rand_range(2, 19), 3, 3);
        draw_rect_outline(rand_range(20, 25), rand_range(2, 18), 4, 4);
        // Left side lies in the border, so the window sees an open shape
        draw_rect_outline(0, 10, 7, 7);
        set_pixel(1, 3);
        set_pixel(`ZC_IMG_WIDTH - 1, 5);
        exp = expected_result();
        assert (exp.stripe_count == 0 && !exp.crossing) else begin
            $display("Error in short_outlines: model counts a short or open outline");
            error_cnt++;
        end
        load_frame();
        run_pass("short_outlines", exp);
        report_test("short_outlines", errs);
    endtask

    task automatic random_mix();
        int errs;
        int i;
        int r;
        int rects;
        zc_pkg::zc_result_t exp;
        errs = error_cnt;
        for (i = 0; i < 20; i++) begin
            clear_frame();
            rects = rand_range(0, 4);
            for (r = 0; r < rects; r++) begin
                draw_rect_outline(rand_range(0, 28), rand_range(0, 20),
                                  rand_range(3, 10), rand_range(3, 10));
            end
            scatter_noise(rand_range(5, 30));
            exp = expected_result();
            load_frame();
            run_pass($sformatf("random_mix[%0d]", i), exp);
        end
        report_test("random_mix", errs);
    endtask

    task automatic busy_restart();
        int errs;
        int i;
        bit seen;
        zc_pkg::zc_result_t exp;
        zc_pkg::zc_result_t held;
        errs = error_cnt;
        clear_frame();
        for (i = 0; i < 4; i++) begin
            draw_rect_outline(rand_range(2, 22), rand_range(2, 14),
                              rand_range(4, 8), rand_range(4, 8));
        end
        exp = expected_result();
        load_frame();
        pulse_start();
        repeat (10) tick();
        // Second start in the middle of the pass
        pulse_start();
        wait_for_done("busy_restart first pass", seen);
        if (seen) begin
            check_result("busy_restart first pass", exp);
        end
        held = exp;
        for (i = 0; i < IDLE_WATCH; i++) begin
            tick();
            assert (!done && !busy) else begin
                $display("Error in busy_restart: DUT active again after done");
                error_cnt++;
            end
        end
        clear_frame();
        draw_rect_outline(rand_range(2, 10), rand_range(2, 8), 6, 7);
        draw_rect_outline(rand_range(16, 22), rand_range(2, 8), 5, 8);
        scatter_noise(10);
        exp = expected_result();
        load_frame();
        check_result("busy_restart held result", held);
        run_pass("busy_restart second pass", exp);
        report_test("busy_restart", errs);
    endtask

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        start = 1'b0;
        pix_wr = '0;
        lcg_state = 32'd84649;
        error_cnt = 0;
        pass_cnt = 0;
        fail_cnt = 0;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        empty_frame();
        three_stripes();
        short_outlines();
        random_mix();
        busy_restart();
        $display("Tests finished: %0d passed, %0d failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && error_cnt == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: zebra_crossing_detector.sv
`timescale 1ns/1ps
`default_nettype none

module zebra_crossing_detector (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire zc_pkg::pix_wr_t pix_wr,
    input  wire                  start,
    output logic                 busy,
    output logic                 done,
    output zc_pkg::zc_result_t   result
);

    zc_pkg::pix_addr_t frame_rd_addr;
    logic              frame_rd_data;
    logic              clr_start;
    logic              clr_busy;
    logic              mark_en;
    zc_pkg::pix_addr_t mark_addr;
    zc_pkg::pix_addr_t test_addr;
    logic              visited;
    logic              scan_restart;
    logic              scan_advance;
    logic              scan_load;
    zc_pkg::pix_pos_t  scan_load_pos;
    zc_pkg::pix_pos_t  scan_pos;
    logic              scan_last;

    edge_frame_ram i_frame_ram (
        .clk     (clk),
        .wr      (pix_wr),
        .rd_addr (frame_rd_addr),
        .rd_data (frame_rd_data)
    );

    visited_map i_visited_map (
        .clk       (clk),
        .rst_n     (rst_n),
        .clr_start (clr_start),
        .clr_busy  (clr_busy),
        .mark_en   (mark_en),
        .mark_addr (mark_addr),
        .test_addr (test_addr),
        .visited   (visited)
    );

    raster_scan_counter i_scan_counter (
        .clk      (clk),
        .rst_n    (rst_n),
        .restart  (scan_restart),
        .advance  (scan_advance),
        .load     (scan_load),
        .load_pos (scan_load_pos),
        .pos      (scan_pos),
        .last     (scan_last)
    );

    contour_tracer_fsm i_tracer (
        .clk           (clk),
        .rst_n         (rst_n),
        .start         (start),
        .busy          (busy),
        .done          (done),
        .result        (result),
        .rd_addr       (frame_rd_addr),
        .rd_data       (frame_rd_data),
        .clr_start     (clr_start),
        .clr_busy      (clr_busy),
        .mark_en       (mark_en),
        .mark_addr     (mark_addr),
        .test_addr     (test_addr),
        .visited       (visited),
        .scan_restart  (scan_restart),
        .scan_advance  (scan_advance),
        .scan_load     (scan_load),
        .scan_load_pos (scan_load_pos),
        .scan_pos      (scan_pos),
        .scan_last     (scan_last)
    );

endmodule

`default_nettype wire

// File: contour_tracer_fsm.sv
`timescale 1ns/1ps
`default_nettype none

`include "zc_params.svh"

module contour_tracer_fsm (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    start,
    output logic                   busy,
    output logic                   done,
    output zc_pkg::zc_result_t     result,
    output zc_pkg::pix_addr_t      rd_addr,
    input  wire                    rd_data,
    output logic                   clr_start,
    input  wire                    clr_busy,
    output logic                   mark_en,
    output zc_pkg::pix_addr_t      mark_addr,
    output zc_pkg::pix_addr_t      test_addr,
    input  wire                    visited,
    output logic                   scan_restart,
    output logic                   scan_advance,
    output logic                   scan_load,
    output zc_pkg::pix_pos_t       scan_load_pos,
    input  wire zc_pkg::pix_pos_t  scan_pos,
    input  wire                    scan_last
);

    localparam int X_MIN = `ZC_BORDER;
    localparam int X_MAX = `ZC_IMG_WIDTH - `ZC_BORDER - 1;
    localparam int Y_MIN = `ZC_BORDER;
    localparam int Y_MAX = `ZC_IMG_HEIGHT - `ZC_BORDER - 1;

    // Neighbor order NW, N, NE, W, E, SW, S, SE
    localparam int NBR_DX [8] = '{-1, 0, 1, -1, 1, -1, 0, 1};
    localparam int NBR_DY [8] = '{-1, -1, -1, 0, 0, 1, 1, 1};

    zc_pkg::trace_state_t state;
    zc_pkg::stripe_cnt_t  stripe_cnt;
    zc_pkg::edge_len_t    trace_len;
    zc_pkg::pix_pos_t     chk_pos;
    zc_pkg::pix_pos_t     start_pos;
    zc_pkg::pix_pos_t     cur_pos;
    zc_pkg::pix_pos_t     prev_pos;
    zc_pkg::pix_pos_t     nbr_pos;
    zc_pkg::pix_addr_t    chk_addr;
    zc_pkg::pix_addr_t    nbr_addr;
    logic [2:0]           nbr_idx;
    logic                 chk_valid;
    logic                 chk_last;
    logic                 nbr_in_win;
    logic                 scan_hit;
    logic                 scan_finish;
    logic                 nbr_closes;
    logic                 nbr_follow;
    logic                 nbr_fail;
    int                   nx;
    int                   ny;

    function automatic zc_pkg::pix_addr_t pos_addr(input zc_pkg::pix_pos_t p);
        return zc_pkg::pix_addr_t'(p.y) * zc_pkg::pix_addr_t'(`ZC_IMG_WIDTH)
             + zc_pkg::pix_addr_t'(p.x);
    endfunction

    always_comb begin
        nx = int'(cur_pos.x) + NBR_DX[nbr_idx];
        ny = int'(cur_pos.y) + NBR_DY[nbr_idx];
        nbr_in_win = (nx >= X_MIN) && (nx <= X_MAX) && (ny >= Y_MIN) && (ny <= Y_MAX);
        nbr_pos.x = zc_pkg::coord_x_t'(nx);
        nbr_pos.y = zc_pkg::coord_y_t'(ny);
    end

    assign chk_addr = pos_addr(chk_pos);
    assign nbr_addr = pos_addr(nbr_pos);

    // Scan reads the counter position, tracing reads the neighbor
    assign rd_addr   = (state == zc_pkg::SCAN) ? pos_addr(scan_pos) : nbr_addr;
    assign test_addr = (state == zc_pkg::SCAN) ? chk_addr : nbr_addr;
    assign mark_addr = (state == zc_pkg::SCAN) ? chk_addr : nbr_addr;

    // rd_data belongs to chk_pos while scanning
    assign scan_hit    = (state == zc_pkg::SCAN) && chk_valid && rd_data && !visited;
    assign scan_finish = (state == zc_pkg::SCAN) && chk_valid && chk_last && !scan_hit;

    assign nbr_closes = (state == zc_pkg::READ_NEIGHBOR) && rd_data
                     && (nbr_pos == start_pos)
                     && (trace_len >= zc_pkg::edge_len_t'(`ZC_MIN_EDGE_LENGTH));
    assign nbr_follow = (state == zc_pkg::READ_NEIGHBOR) && rd_data && !nbr_closes
                     && !visited && (nbr_pos != prev_pos);
    assign nbr_fail   = ((state == zc_pkg::TEST_NEIGHBOR) && !nbr_in_win)
                     || ((state == zc_pkg::READ_NEIGHBOR) && !nbr_closes && !nbr_follow);

    assign clr_start     = (state == zc_pkg::IDLE) && start;
    assign scan_restart  = clr_start;
    assign scan_advance  = (state == zc_pkg::SCAN) && !scan_hit && !scan_finish && !scan_last;
    assign scan_load     = nbr_closes || (nbr_fail && (nbr_idx == 3'd7));
    assign scan_load_pos = start_pos;
    assign mark_en       = scan_hit || nbr_follow;

    assign busy = (state != zc_pkg::IDLE);
    assign done = (state == zc_pkg::REPORT);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= zc_pkg::IDLE;
            chk_valid  <= 1'b0;
            nbr_idx    <= '0;
            stripe_cnt <= '0;
            result     <= '0;
        end else begin
            case (state)
                zc_pkg::IDLE: begin
                    if (start) begin
                        stripe_cnt <= '0;
                        state      <= zc_pkg::CLEAR;
                    end
                end
                zc_pkg::CLEAR: begin
                    if (!clr_busy) begin
                        chk_valid <= 1'b0;
                        state     <= zc_pkg::SCAN;
                    end
                end
                zc_pkg::SCAN: begin
                    if (scan_hit) begin
                        chk_valid <= 1'b0;
                        nbr_idx   <= '0;
                        state     <= zc_pkg::TEST_NEIGHBOR;
                    end else if (scan_finish) begin
                        result.stripe_count <= stripe_cnt;
                        result.crossing <=
                            (stripe_cnt >= zc_pkg::stripe_cnt_t'(`ZC_MIN_STRIPES));
                        state <= zc_pkg::REPORT;
                    end else begin
                        chk_valid <= 1'b1;
                    end
                end
                zc_pkg::TEST_NEIGHBOR, zc_pkg::READ_NEIGHBOR: begin
                    if (scan_load) begin
                        // Contour over, counter is reloaded with its start
                        if (nbr_closes) begin
                            stripe_cnt <= stripe_cnt + 1'b1;
                        end
                        chk_valid <= 1'b0;
                        state     <= zc_pkg::SCAN;
                    end else if (nbr_follow) begin
                        nbr_idx <= '0;
                        state   <= zc_pkg::TEST_NEIGHBOR;
                    end else if (nbr_fail) begin
                        nbr_idx <= nbr_idx + 1'b1;
                        state   <= zc_pkg::TEST_NEIGHBOR;
                    end else begin
                        state <= zc_pkg::READ_NEIGHBOR;
                    end
                end
                zc_pkg::REPORT: begin
                    state <= zc_pkg::IDLE;
                end
                default: begin
                    state <= zc_pkg::IDLE;
                end
            endcase
        end
    end

    // Contour positions and length
    always_ff @(posedge clk) begin
        if ((state == zc_pkg::SCAN) && !scan_hit) begin
            chk_pos  <= scan_pos;
            chk_last <= scan_last;
        end
        if (scan_hit) begin
            start_pos <= chk_pos;
            cur_pos   <= chk_pos;
            prev_pos  <= chk_pos;
            trace_len <= zc_pkg::edge_len_t'(1);
        end else if (nbr_follow) begin
            prev_pos  <= cur_pos;
            cur_pos   <= nbr_pos;
            trace_len <= trace_len + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: raster_scan_counter.sv
`timescale 1ns/1ps
`default_nettype none

`include "zc_params.svh"

module raster_scan_counter (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   restart,
    input  wire                   advance,
    input  wire                   load,
    input  wire zc_pkg::pix_pos_t load_pos,
    output zc_pkg::pix_pos_t      pos,
    output logic                  last
);

    // Window corners
    localparam zc_pkg::coord_x_t X_FIRST = zc_pkg::coord_x_t'(`ZC_BORDER);
    localparam zc_pkg::coord_x_t X_LAST =
        zc_pkg::coord_x_t'(`ZC_IMG_WIDTH - `ZC_BORDER - 1);
    localparam zc_pkg::coord_y_t Y_FIRST = zc_pkg::coord_y_t'(`ZC_BORDER);
    localparam zc_pkg::coord_y_t Y_LAST =
        zc_pkg::coord_y_t'(`ZC_IMG_HEIGHT - `ZC_BORDER - 1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pos.x <= X_FIRST;
            pos.y <= Y_FIRST;
        end else if (restart) begin
            pos.x <= X_FIRST;
            pos.y <= Y_FIRST;
        end else if (load) begin
            pos <= load_pos;
        end else if (advance) begin
            if (pos.x == X_LAST) begin
                pos.x <= X_FIRST;
                // Wrap back to the top after the final row
                if (pos.y == Y_LAST) begin
                    pos.y <= Y_FIRST;
                end else begin
                    pos.y <= pos.y + 1'b1;
                end
            end else begin
                pos.x <= pos.x + 1'b1;
            end
        end
    end

    assign last = (pos.x == X_LAST) && (pos.y == Y_LAST);

endmodule

`default_nettype wire

// File: visited_map.sv
`timescale 1ns/1ps
`default_nettype none

module visited_map (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    clr_start,
    output logic                   clr_busy,
    input  wire                    mark_en,
    input  wire zc_pkg::pix_addr_t mark_addr,
    input  wire zc_pkg::pix_addr_t test_addr,
    output logic                   visited
);

    localparam zc_pkg::pix_addr_t LAST_ADDR = zc_pkg::pix_addr_t'(zc_pkg::PIX_COUNT - 1);

    logic              bits [zc_pkg::PIX_COUNT];
    zc_pkg::pix_addr_t clr_addr;

    // Sweep controller, one address per cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            clr_busy <= 1'b0;
            clr_addr <= '0;
        end else if (clr_start && !clr_busy) begin
            clr_busy <= 1'b1;
            clr_addr <= '0;
        end else if (clr_busy) begin
            if (clr_addr == LAST_ADDR) begin
                clr_busy <= 1'b0;
            end
            clr_addr <= clr_addr + 1'b1;
        end
    end

    // Clear wins over a mark while the sweep runs
    always_ff @(posedge clk) begin
        if (clr_busy) begin
            bits[clr_addr] <= 1'b0;
        end else if (mark_en) begin
            bits[mark_addr] <= 1'b1;
        end
    end

    assign visited = bits[test_addr];

endmodule

`default_nettype wire

// File: edge_frame_ram.sv
`timescale 1ns/1ps
`default_nettype none

module edge_frame_ram (
    input  wire                 clk,
    input  wire zc_pkg::pix_wr_t   wr,
    input  wire zc_pkg::pix_addr_t rd_addr,
    output logic                rd_data
);

    // One bit per pixel, no reset so it maps onto block memory
    logic mem [zc_pkg::PIX_COUNT];

    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // Registered read, data follows the address by one cycle
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// File: zc_pkg.sv
`default_nettype none

`include "zc_params.svh"

package zc_pkg;

    localparam int unsigned PIX_COUNT = `ZC_IMG_WIDTH * `ZC_IMG_HEIGHT;

    typedef logic [$clog2(`ZC_IMG_WIDTH)-1:0] coord_x_t;
    typedef logic [$clog2(`ZC_IMG_HEIGHT)-1:0] coord_y_t;
    typedef logic [$clog2(PIX_COUNT)-1:0] pix_addr_t;
    typedef logic [15:0] edge_len_t;
    typedef logic [7:0] stripe_cnt_t;

    typedef enum logic [2:0] {
        IDLE,
        CLEAR,
        SCAN,
        TEST_NEIGHBOR,
        READ_NEIGHBOR,
        REPORT
    } trace_state_t;

    typedef struct packed {
        coord_x_t x;
        coord_y_t y;
    } pix_pos_t;

    // One pixel write into the frame memory
    typedef struct packed {
        logic      en;
        pix_addr_t addr;
        logic      data;
    } pix_wr_t;

    typedef struct packed {
        stripe_cnt_t stripe_count;
        logic        crossing;
    } zc_result_t;

endpackage

`default_nettype wire

// File: zc_params.svh
`ifndef ZC_PARAMS_SVH
`define ZC_PARAMS_SVH

// Image geometry in pixels
`define ZC_IMG_WIDTH 32
`define ZC_IMG_HEIGHT 24

// Margin skipped on every side of the frame
`define ZC_BORDER 2

// Shortest closed contour that still counts as a stripe
`define ZC_MIN_EDGE_LENGTH 12

// Stripes needed before a crossing is declared
`define ZC_MIN_STRIPES 3

`endif
